// File: rtl/backendPkg.sv
package backendPkg;

    localparam int archRegs = 32;
    localparam int physRegs = 48;
    localparam int robSize = 16;
    localparam int freeSize = physRegs - archRegs;

    typedef logic [$clog2(physRegs)-1:0] PhysIdx;
    typedef logic [$clog2(robSize)-1:0] RobIdx;
    typedef logic [$clog2(archRegs)-1:0] ArchIdx;
    typedef logic [$clog2(robSize):0] RobCount;
    typedef logic [$clog2(freeSize)-1:0] FreePtr;
    typedef logic [$clog2(freeSize):0] FreeCount;

    // major opcodes of the supported RV32I subset.
    typedef enum logic [6:0] {
        opReg = 7'b0110011,
        opImm = 7'b0010011,
        opLui = 7'b0110111
    } Opcode;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluPass
    } AluOp;

    typedef struct packed {
        logic valid;
        AluOp aluOp;
        ArchIdx rd;
        ArchIdx rs1;
        ArchIdx rs2;
        logic useImm;
        logic [31:0] imm;
        logic writes;
    } DecodedOp;

    typedef struct packed {
        logic valid;
        AluOp aluOp;
        logic useImm;
        logic [31:0] imm;
        logic writes;
        PhysIdx prd;
        PhysIdx prs1;
        PhysIdx prs2;
        RobIdx robIdx;
    } RenamedOp;

    typedef struct packed {
        logic valid;
        AluOp aluOp;
        logic [31:0] a;
        logic [31:0] b;
        PhysIdx prd;
        logic writes;
        RobIdx robIdx;
    } ExecOp;

    typedef struct packed {
        logic valid;
        PhysIdx prd;
        logic writes;
        RobIdx robIdx;
        logic [31:0] data;
    } WriteBack;

    typedef struct packed {
        logic valid;
        ArchIdx archRd;
        logic writes;
        PhysIdx prd;
        PhysIdx oldPrd;
    } RobAlloc;

    typedef struct packed {
        logic valid;
        ArchIdx archRd;
        logic writes;
        logic [31:0] data;
    } CommitBus;

endpackage

// File: rtl/decode.sv
`timescale 1ns/100ps

module decode import backendPkg::*; (
    input logic clk,
    input logic reset,
    input logic fetchValid,
    input logic [31:0] fetchInst,
    input logic renameStall,
    output DecodedOp decoded,
    output logic fetchStall
);
    DecodedOp nextOp;
    logic supported;

    // an empty decode register takes the word even while rename stalls.
    assign fetchStall = renameStall && decoded.valid;

    always_comb begin
        nextOp = '0;
        nextOp.valid = fetchValid;
        nextOp.aluOp = aluAdd;
        nextOp.rd = fetchInst[11:7];
        nextOp.rs1 = fetchInst[19:15];
        nextOp.rs2 = fetchInst[24:20];
        nextOp.imm = {{20{fetchInst[31]}}, fetchInst[31:20]};
        supported = 1'b1;
        case (fetchInst[6:0])
            opReg: begin
                case ({fetchInst[31:25], fetchInst[14:12]})
                    10'b0000000_000: nextOp.aluOp = aluAdd;
                    10'b0100000_000: nextOp.aluOp = aluSub;
                    10'b0000000_111: nextOp.aluOp = aluAnd;
                    10'b0000000_110: nextOp.aluOp = aluOr;
                    10'b0000000_100: nextOp.aluOp = aluXor;
                    10'b0000000_010: nextOp.aluOp = aluSlt;
                    default: supported = 1'b0;
                endcase
            end
            opImm: begin
                nextOp.useImm = 1'b1;
                nextOp.rs2 = '0;
                case (fetchInst[14:12])
                    3'b000: nextOp.aluOp = aluAdd;
                    3'b111: nextOp.aluOp = aluAnd;
                    3'b110: nextOp.aluOp = aluOr;
                    3'b100: nextOp.aluOp = aluXor;
                    default: supported = 1'b0;
                endcase
            end
            opLui: begin
                nextOp.aluOp = aluPass;
                nextOp.useImm = 1'b1;
                nextOp.rs1 = '0;
                nextOp.rs2 = '0;
                nextOp.imm = {fetchInst[31:12], 12'b0};
            end
            default: supported = 1'b0;
        endcase
        // unsupported words still flow to commit without sources or a target.
        if (!supported) begin
            nextOp.rd = '0;
            nextOp.rs1 = '0;
            nextOp.rs2 = '0;
            nextOp.useImm = 1'b0;
        end
        nextOp.writes = supported && (nextOp.rd != '0);
    end

    always_ff @(posedge clk) begin
        if (!fetchStall) begin
            decoded <= nextOp;
        end
        if (reset) begin
            decoded.valid <= 1'b0;
        end
    end

endmodule

// File: rtl/rename.sv
`timescale 1ns/100ps

module rename import backendPkg::*; (
    input logic clk,
    input logic reset,
    input DecodedOp decoded,
    input logic issueStall,
    input RobIdx robIdx,
    input logic robFull,
    input logic retireValid,
    input PhysIdx retireOldPrd,
    output RenamedOp renamed,
    output RobAlloc alloc,
    output logic renameStall
);
    PhysIdx aliasTable [archRegs];
    PhysIdx freeList [freeSize];
    FreePtr freeHead;
    FreePtr freeTail;
    FreeCount freeCount;
    RenamedOp nextOp;
    PhysIdx newPrd;
    logic holdOut;
    logic fire;
    logic takeReg;

    assign holdOut = renamed.valid && issueStall;
    assign renameStall = holdOut || robFull
        || (decoded.valid && decoded.writes && (freeCount == '0));
    assign fire = decoded.valid && !renameStall;
    assign takeReg = fire && decoded.writes;

    // non-writing ops park on p0, which never goes busy.
    assign newPrd = decoded.writes ? freeList[freeHead] : '0;

    always_comb begin
        nextOp.valid = fire;
        nextOp.aluOp = decoded.aluOp;
        nextOp.useImm = decoded.useImm;
        nextOp.imm = decoded.imm;
        nextOp.writes = decoded.writes;
        nextOp.prd = newPrd;
        nextOp.prs1 = aliasTable[decoded.rs1];
        nextOp.prs2 = aliasTable[decoded.rs2];
        nextOp.robIdx = robIdx;
    end

    always_comb begin
        alloc.valid = fire;
        alloc.archRd = decoded.rd;
        alloc.writes = decoded.writes;
        alloc.prd = newPrd;
        alloc.oldPrd = aliasTable[decoded.rd];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < archRegs; i++) begin
                aliasTable[i] <= PhysIdx'(i);
            end
            for (int i = 0; i < freeSize; i++) begin
                freeList[i] <= PhysIdx'(archRegs + i);
            end
            freeHead <= '0;
            freeTail <= '0;
            freeCount <= FreeCount'(freeSize);
        end else begin
            if (takeReg) begin
                aliasTable[decoded.rd] <= freeList[freeHead];
                freeHead <= freeHead + 1'b1;
            end
            // the retiring op's previous mapping has no readers left.
            if (retireValid) begin
                freeList[freeTail] <= retireOldPrd;
                freeTail <= freeTail + 1'b1;
            end
            freeCount <= freeCount + FreeCount'(retireValid) - FreeCount'(takeReg);
        end
    end

    always_ff @(posedge clk) begin
        if (!holdOut) begin
            renamed <= nextOp;
        end
        if (reset) begin
            renamed.valid <= 1'b0;
        end
    end

endmodule

// File: rtl/issue.sv
`timescale 1ns/100ps

module issue import backendPkg::*; (
    input logic clk,
    input logic reset,
    input RenamedOp renamed,
    input WriteBack wb,
    output PhysIdx rdAddrA,
    output PhysIdx rdAddrB,
    input logic [31:0] rdDataA,
    input logic [31:0] rdDataB,
    output ExecOp execOp,
    output logic issueStall
);
    RenamedOp slot;
    logic [physRegs-1:0] busy;
    logic wakeValid;
    logic readyA;
    logic readyB;
    logic ready;

    assign wakeValid = wb.valid && wb.writes;

    // a wakeup in flight counts as ready, so dependent ops go back to back.
    assign readyA = (slot.prs1 == '0) || !busy[slot.prs1]
        || (wakeValid && (wb.prd == slot.prs1));
    assign readyB = (slot.prs2 == '0) || !busy[slot.prs2]
        || (wakeValid && (wb.prd == slot.prs2));
    assign ready = readyA && readyB;
    assign issueStall = slot.valid && !ready;

    assign rdAddrA = slot.prs1;
    assign rdAddrB = slot.prs2;

    always_comb begin
        execOp.valid = slot.valid && ready;
        execOp.aluOp = slot.aluOp;
        execOp.a = rdDataA;
        execOp.b = slot.useImm ? slot.imm : rdDataB;
        execOp.prd = slot.prd;
        execOp.writes = slot.writes;
        execOp.robIdx = slot.robIdx;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (wakeValid) begin
                busy[wb.prd] <= 1'b0;
            end
            if (renamed.valid && renamed.writes && !issueStall) begin
                busy[renamed.prd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!issueStall) begin
            slot <= renamed;
        end
        if (reset) begin
            slot.valid <= 1'b0;
        end
    end

endmodule

// File: rtl/regFile.sv
`timescale 1ns/100ps

module regFile import backendPkg::*; (
    input logic clk,
    input logic reset,
    input PhysIdx rdAddrA,
    input PhysIdx rdAddrB,
    output logic [31:0] rdDataA,
    output logic [31:0] rdDataB,
    input WriteBack wb
);
    logic [31:0] regs [physRegs];
    logic writeEn;

    assign writeEn = wb.valid && wb.writes && (wb.prd != '0);

    // same-cycle writeback forwards straight to the read ports.
    assign rdDataA = (rdAddrA == '0) ? '0
        : (writeEn && (wb.prd == rdAddrA)) ? wb.data : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0
        : (writeEn && (wb.prd == rdAddrB)) ? wb.data : regs[rdAddrB];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < physRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[wb.prd] <= wb.data;
        end
    end

endmodule

// File: rtl/execute.sv
`timescale 1ns/100ps

module execute import backendPkg::*; (
    input logic clk,
    input logic reset,
    input ExecOp execOp,
    output WriteBack wb
);
    logic [31:0] result;

    always_comb begin
        case (execOp.aluOp)
            aluAdd: result = execOp.a + execOp.b;
            aluSub: result = execOp.a - execOp.b;
            aluAnd: result = execOp.a & execOp.b;
            aluOr: result = execOp.a | execOp.b;
            aluXor: result = execOp.a ^ execOp.b;
            aluSlt: result = {31'b0, $signed(execOp.a) < $signed(execOp.b)};
            // lui carries its value in operand b.
            default: result = execOp.b;
        endcase
    end

    always_ff @(posedge clk) begin
        wb.prd <= execOp.prd;
        wb.writes <= execOp.writes;
        wb.robIdx <= execOp.robIdx;
        wb.data <= result;
        if (reset) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= execOp.valid;
        end
    end

endmodule

// File: rtl/reorderBuffer.sv
`timescale 1ns/100ps

module reorderBuffer import backendPkg::*; (
    input logic clk,
    input logic reset,
    input RobAlloc alloc,
    input WriteBack wb,
    output RobIdx robIdx,
    output logic robFull,
    output logic retireValid,
    output PhysIdx retireOldPrd,
    output CommitBus commit
);
    typedef struct packed {
        ArchIdx archRd;
        logic writes;
        PhysIdx oldPrd;
    } RobEntry;

    RobEntry entries [robSize];
    logic [31:0] results [robSize];
    logic [robSize-1:0] done;
    RobIdx head;
    RobIdx tail;
    RobCount count;
    logic retire;

    assign robIdx = tail;
    assign robFull = (count == RobCount'(robSize));
    assign retire = (count != '0) && done[head];

    // freed register goes back to rename on the same edge the head retires.
    assign retireValid = retire && entries[head].writes;
    assign retireOldPrd = entries[head].oldPrd;

    always_ff @(posedge clk) begin
        if (alloc.valid) begin
            entries[tail] <= {alloc.archRd, alloc.writes, alloc.oldPrd};
        end
        if (wb.valid) begin
            results[wb.robIdx] <= wb.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            done <= '0;
        end else begin
            if (alloc.valid) begin
                done[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end
            if (wb.valid) begin
                done[wb.robIdx] <= 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count <= count + RobCount'(alloc.valid) - RobCount'(retire);
        end
    end

    always_ff @(posedge clk) begin
        commit.archRd <= entries[head].archRd;
        commit.writes <= entries[head].writes;
        commit.data <= results[head];
        if (reset) begin
            commit.valid <= 1'b0;
        end else begin
            commit.valid <= retire;
        end
    end

endmodule

// File: rtl/backend.sv
`timescale 1ns/100ps

module backend import backendPkg::*; (
    input logic clk,
    input logic reset,
    input logic fetchValid,
    input logic [31:0] fetchInst,
    output logic fetchStall,
    output CommitBus commit
);
    DecodedOp decoded;
    RenamedOp renamed;
    RobAlloc alloc;
    ExecOp execOp;
    WriteBack wb;
    logic renameStall;
    logic issueStall;
    logic robFull;
    logic retireValid;
    RobIdx robIdx;
    PhysIdx retireOldPrd;
    PhysIdx rdAddrA;
    PhysIdx rdAddrB;
    logic [31:0] rdDataA;
    logic [31:0] rdDataB;

    decode decode_i (.*);

    // rename allocates the ROB tail in the cycle it registers its op.
    rename rename_i (.*);

    issue issue_i (.*);

    regFile regFile_i (.*);

    execute execute_i (.*);

    reorderBuffer reorderBuffer_i (.*);

endmodule

// File: verification/backendModel.svh
`ifndef BACKEND_MODEL_SVH
`define BACKEND_MODEL_SVH

// architectural registers as the program sees them.
logic [31:0] archState [archRegs];

function automatic logic [31:0] encR(input int funct7, input int funct3, input int rd,
                                     input int rs1, input int rs2);
    return {7'(funct7), 5'(rs2), 5'(rs1), 3'(funct3), 5'(rd), 7'b0110011};
endfunction

function automatic logic [31:0] encI(input int funct3, input int rd, input int rs1,
                                     input int imm);
    return {12'(imm), 5'(rs1), 3'(funct3), 5'(rd), 7'b0010011};
endfunction

function automatic logic [31:0] encLui(input int rd, input int imm20);
    return {20'(imm20), 5'(rd), 7'b0110111};
endfunction

// executes one word in program order and returns the commit it must produce.
function automatic CommitBus modelStep(input logic [31:0] word);
    CommitBus result;
    ArchIdx rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic known;
    rd = word[11:7];
    a = archState[word[19:15]];
    b = archState[word[24:20]];
    immI = {{20{word[31]}}, word[31:20]};
    known = 1'b1;
    result = '0;
    result.valid = 1'b1;
    case (word[6:0])
        7'b0110011: begin
            case ({word[31:25], word[14:12]})
                10'b0000000_000: result.data = a + b;
                10'b0100000_000: result.data = a - b;
                10'b0000000_111: result.data = a & b;
                10'b0000000_110: result.data = a | b;
                10'b0000000_100: result.data = a ^ b;
                10'b0000000_010: result.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default: known = 1'b0;
            endcase
        end
        7'b0010011: begin
            case (word[14:12])
                3'b000: result.data = a + immI;
                3'b111: result.data = a & immI;
                3'b110: result.data = a | immI;
                3'b100: result.data = a ^ immI;
                default: known = 1'b0;
            endcase
        end
        7'b0110111: result.data = word & 32'hffff_f000;
        default: known = 1'b0;
    endcase
    if (known && (rd != '0)) begin
        result.archRd = rd;
        result.writes = 1'b1;
        archState[rd] = result.data;
    end
    return result;
endfunction

`endif

// File: verification/backendTb.sv
`timescale 1ns/100ps

module backendTb import backendPkg::*; ();

    localparam int directedWords = 40;
    localparam int longRunWords = 40;
    localparam int randomWords = 500;
    localparam int cycleLimit = 8 * (directedWords + longRunWords + randomWords) + 200;

    logic clk;
    logic reset;
    logic fetchValid;
    logic [31:0] fetchInst;
    logic fetchStall;
    CommitBus commit;

    CommitBus expQ [$];
    CommitBus expHead;
    logic expAvail;
    logic started;
    string testName;
    int cycles;

    `include "backendModel.svh"

    backend backend_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic void refreshHead();
        expAvail = (expQ.size() != 0);
        if (expAvail) begin
            expHead = expQ[0];
        end
    endfunction

    // fetch keeps the word in place until a cycle without fetchStall takes it.
    task automatic sendWord(input logic [31:0] word);
        logic taken;
        expQ.push_back(modelStep(word));
        refreshHead();
        taken = 1'b0;
        while (!taken) begin
            fetchValid = 1'b1;
            fetchInst = word;
            #1;
            taken = !fetchStall;
            @(posedge clk);
            #10;
        end
        started = 1'b1;
    endtask

    task automatic idleCycles(input int n);
        fetchValid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    function automatic logic [31:0] randomWord();
        logic [31:0] word;
        int rd;
        int rs1;
        int rs2;
        int pick;
        // a small register window keeps dependencies frequent.
        rd = $urandom_range(0, 15);
        rs1 = $urandom_range(0, 15);
        rs2 = $urandom_range(0, 15);
        pick = $urandom_range(0, 11);
        case (pick)
            0: word = encR(0, 0, rd, rs1, rs2);
            1: word = encR(32, 0, rd, rs1, rs2);
            2: word = encR(0, 7, rd, rs1, rs2);
            3: word = encR(0, 6, rd, rs1, rs2);
            4: word = encR(0, 4, rd, rs1, rs2);
            5: word = encR(0, 2, rd, rs1, rs2);
            6: word = encI(0, rd, rs1, $urandom_range(0, 4095));
            7: word = encI(7, rd, rs1, $urandom_range(0, 4095));
            8: word = encI(6, rd, rs1, $urandom_range(0, 4095));
            9: word = encI(4, rd, rs1, $urandom_range(0, 4095));
            10: word = encLui(rd, $urandom_range(0, 20'hfffff));
            default: word = $urandom();
        endcase
        return word;
    endfunction

    always @(posedge clk) begin
        if (!reset && commit.valid && expAvail) begin
            expQ.delete(0);
            refreshHead();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            failRun($sformatf("timeout after %0d cycles with %0d commits outstanding",
                cycles, expQ.size()));
        end
    end

    // nothing leaves fetch or commit before the first word goes in.
    idleAfterReset: assert property (@(negedge clk) disable iff (reset)
        !started |-> !fetchStall && !commit.valid)
        else failRun("fetchStall or commit.valid rose before any word was taken");

    noSpareCommit: assert property (@(negedge clk) disable iff (reset)
        commit.valid |-> expAvail)
        else failRun("a commit arrived with no instruction outstanding");

    rdMatches: assert property (@(negedge clk) disable iff (reset)
        commit.valid && expAvail |-> commit.archRd == expHead.archRd)
        else failRun($sformatf("ERR %s rd expected %0d actual %0d",
            testName, expHead.archRd, commit.archRd));

    writesMatches: assert property (@(negedge clk) disable iff (reset)
        commit.valid && expAvail |-> commit.writes == expHead.writes)
        else failRun($sformatf("ERR %s writes expected %0b actual %0b",
            testName, expHead.writes, commit.writes));

    dataMatches: assert property (@(negedge clk) disable iff (reset)
        commit.valid && expAvail && expHead.writes |-> commit.data == expHead.data)
        else failRun($sformatf("ERR %s data expected %h actual %h",
            testName, expHead.data, commit.data));

    initial begin
        reset = 1'b1;
        fetchValid = 1'b0;
        fetchInst = '0;
        started = 1'b0;
        cycles = 0;
        expAvail = 1'b0;
        expHead = '0;
        testName = "reset";
        for (int i = 0; i < archRegs; i++) begin
            archState[i] = '0;
        end
        void'($urandom(13));
        repeat (10) @(posedge clk);
        #10;
        reset = 1'b0;
        idleCycles(5);

        testName = "aluOps";
        sendWord(encI(0, 1, 0, 100));
        sendWord(encI(0, 2, 0, -7));
        sendWord(encR(0, 0, 3, 1, 2));
        sendWord(encR(32, 0, 4, 1, 2));
        sendWord(encR(0, 7, 5, 1, 2));
        sendWord(encR(0, 6, 6, 1, 2));
        sendWord(encR(0, 4, 7, 1, 2));
        // signed compare of -7 against 100 both ways.
        sendWord(encR(0, 2, 8, 2, 1));
        sendWord(encR(0, 2, 9, 1, 2));
        sendWord(encI(7, 10, 2, 'h0f0));
        sendWord(encI(6, 11, 1, -256));
        sendWord(encI(4, 12, 2, 'h555));
        sendWord(encLui(13, 'habcde));
        sendWord(encI(0, 13, 13, 'h123));
        idleCycles(3);

        testName = "depChain";
        sendWord(encI(0, 14, 0, 1));
        repeat (6) begin
            sendWord(encR(0, 0, 14, 14, 14));
        end
        sendWord(encR(0, 0, 15, 14, 13));
        sendWord(encR(32, 0, 15, 15, 14));
        sendWord(encR(0, 2, 16, 15, 14));
        idleCycles(3);

        testName = "x0Writes";
        sendWord(encI(0, 0, 1, 55));
        sendWord(encR(0, 0, 0, 1, 2));
        sendWord(encLui(0, 'h12345));
        sendWord(32'h0000_0063);
        sendWord(encR(0, 1, 17, 1, 2));
        sendWord(encI(1, 18, 1, 3));
        sendWord(32'hffff_ffff);
        sendWord(32'h0000_0000);
        sendWord(encR(0, 0, 19, 0, 0));
        sendWord(encI(0, 20, 0, 9));
        idleCycles(3);

        // more writers than free registers, so retired ones must come back.
        testName = "longRun";
        for (int i = 0; i < longRunWords; i++) begin
            if (i % 2 == 0) begin
                sendWord(encI(0, 1 + i % 20, 1 + (i + 3) % 20, i * 3));
            end else begin
                sendWord(encR(0, 0, 1 + i % 20, 1 + (i + 5) % 20, 1 + i % 20));
            end
        end
        idleCycles(3);

        testName = "random";
        for (int i = 0; i < randomWords; i++) begin
            sendWord(randomWord());
            if ($urandom_range(0, 3) == 0) begin
                idleCycles($urandom_range(1, 3));
            end
        end

        testName = "drain";
        idleCycles(1);
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        idleCycles(4);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: sim.f
+incdir+verification
rtl/backendPkg.sv
rtl/decode.sv
rtl/rename.sv
rtl/issue.sv
rtl/regFile.sv
rtl/execute.sv
rtl/reorderBuffer.sv
rtl/backend.sv
verification/backendTb.sv

// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= backendTb
FILELIST ?= sim.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o V$(TOP)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
